// File: source/vec_pkg.sv
`default_nettype none

package vec_pkg;

    // vector geometry
    localparam int DATA_W    = 10;                      // element width
    localparam int VEC_LEN   = 64;                      // elements per vector
    localparam int ADDR_W    = 6;                       // element address width
    localparam int AVG_SHIFT = 6;                       // log2(VEC_LEN), divides the sum
    localparam int ACC_W     = 32;                      // accumulator and result width

    // opcodes as carried in the low 3 bits of a command byte, 7 is ignored
    localparam logic [2:0] OP_WRITE  = 3'd0;
    localparam logic [2:0] OP_READ   = 3'd1;
    localparam logic [2:0] OP_SUM    = 3'd2;
    localparam logic [2:0] OP_AVG    = 3'd3;
    localparam logic [2:0] OP_EUC_SQ = 3'd4;
    localparam logic [2:0] OP_MAN    = 3'd5;
    localparam logic [2:0] OP_DOT    = 3'd6;

    // one-hot command vector, bit order follows the opcodes
    localparam int CMD_W      = 7;
    localparam int CMD_WRITE  = 0;
    localparam int CMD_READ   = 1;
    localparam int CMD_SUM    = 2;
    localparam int CMD_AVG    = 3;
    localparam int CMD_EUC_SQ = 4;
    localparam int CMD_MAN    = 5;
    localparam int CMD_DOT    = 6;

    // command view of a received byte
    typedef struct packed {
        logic       bram_sel;                           // 0 selects A, 1 selects B
        logic [3:0] unused;
        logic [2:0] op_code;
    } rx_cmd_t;

    // a received byte is either a command or a data byte
    typedef union packed {
        rx_cmd_t    cmd;
        logic [7:0] raw;
    } rx_byte_t;

endpackage

`default_nettype wire

// File: source/vector_bram.sv
`timescale 1ns/1ns
`default_nettype none

module vector_bram import vec_pkg::*; (
    input  wire               clk,
    input  wire               we,
    input  wire  [ADDR_W-1:0] wr_addr,
    input  wire  [DATA_W-1:0] wr_data,
    input  wire  [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [VEC_LEN];                   // element storage, contents not reset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;                    // write port
        end
        rd_data <= mem[rd_addr];                        // registered read, one cycle latency
    end

endmodule

`default_nettype wire

// File: source/write_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module write_ctrl import vec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               en,                       // write command held by the decoder
    input  wire               bram_sel,
    input  wire               rx_ready,
    input  wire  rx_byte_t    rx_data,
    output logic              we_a,
    output logic              we_b,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              write_done
);

    logic       hi_phase;                               // next byte is the high byte
    logic [7:0] lo_byte;                                // low byte of the pending element
    logic       we_any;

    assign we_any = we_a | we_b;

    // byte pairing and element assembly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi_phase <= 1'b0;
            we_a     <= 1'b0;
            we_b     <= 1'b0;
        end else begin
            we_a <= 1'b0;                               // write strobes last one cycle
            we_b <= 1'b0;
            if (!en) begin
                hi_phase <= 1'b0;                       // realign on every new write command
            end else if (rx_ready) begin
                hi_phase <= ~hi_phase;
                if (hi_phase) begin
                    we_a <= ~bram_sel;                  // 0 steers to A
                    we_b <= bram_sel;                   // 1 steers to B
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (en && rx_ready && !hi_phase) begin
            lo_byte <= rx_data.raw;
        end
        if (en && rx_ready && hi_phase) begin
            wr_data <= {rx_data.raw[DATA_W-9:0], lo_byte}; // upper 2 bits from the padded byte
        end
    end

    // write address counter, wraps after the last element
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr    <= '0;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            if (we_any) begin
                wr_addr <= wr_addr + 1'b1;              // natural wrap back to 0
                if (wr_addr == ADDR_W'(VEC_LEN - 1)) begin
                    write_done <= 1'b1;                 // whole vector stored
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder import vec_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              rx_ready,
    input  wire  rx_byte_t   rx_data,
    input  wire              op_done,
    output logic [CMD_W-1:0] command,
    output logic             bram_sel,
    output logic             command_ready,
    output logic             busy
);

    logic [CMD_W-1:0] dec_cmd;                          // one-hot of the incoming opcode
    logic             dec_valid;

    // opcode to one-hot
    always_comb begin
        dec_cmd = '0;
        case (rx_data.cmd.op_code)
            OP_WRITE:  dec_cmd[CMD_WRITE]  = 1'b1;
            OP_READ:   dec_cmd[CMD_READ]   = 1'b1;
            OP_SUM:    dec_cmd[CMD_SUM]    = 1'b1;
            OP_AVG:    dec_cmd[CMD_AVG]    = 1'b1;
            OP_EUC_SQ: dec_cmd[CMD_EUC_SQ] = 1'b1;
            OP_MAN:    dec_cmd[CMD_MAN]    = 1'b1;
            OP_DOT:    dec_cmd[CMD_DOT]    = 1'b1;
            default:   dec_cmd = '0;                    // opcode 7, no operation
        endcase
    end

    assign dec_valid = |dec_cmd;

    // idle/busy machine, busy is the state bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            command       <= '0;
            bram_sel      <= 1'b0;
            command_ready <= 1'b0;
        end else begin
            command_ready <= 1'b0;
            if (!busy) begin
                if (rx_ready && dec_valid) begin        // only idle bytes are commands
                    command       <= dec_cmd;
                    bram_sel      <= rx_data.cmd.bram_sel;
                    command_ready <= 1'b1;
                    busy          <= 1'b1;
                end
            end else if (op_done) begin
                command <= '0;                          // release the held command
                busy    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/input_interface.sv
`timescale 1ns/1ns
`default_nettype none

module input_interface import vec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               rx_ready,
    input  wire  rx_byte_t    rx_data,
    input  wire  [ADDR_W-1:0] rd_addr,
    input  wire               exec_done,
    output logic [CMD_W-1:0]  command,
    output logic              bram_sel,
    output logic              command_ready,
    output logic              busy,
    output logic [DATA_W-1:0] data_a,
    output logic [DATA_W-1:0] data_b
);

    logic              we_a;
    logic              we_b;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              write_done;
    logic              op_done;

    assign op_done = exec_done | write_done;            // either side ends the command

    cmd_decoder u_cmd_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_ready      (rx_ready),
        .rx_data       (rx_data),
        .op_done       (op_done),
        .command       (command),
        .bram_sel      (bram_sel),
        .command_ready (command_ready),
        .busy          (busy)
    );

    write_ctrl u_write_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (command[CMD_WRITE]),               // data bytes only while writing
        .bram_sel   (bram_sel),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .we_a       (we_a),
        .we_b       (we_b),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .write_done (write_done)
    );

    vector_bram mem_a (
        .clk     (clk),
        .we      (we_a),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (data_a)
    );

    vector_bram mem_b (
        .clk     (clk),
        .we      (we_b),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (data_b)
    );

endmodule

`default_nettype wire

// File: source/vec_execute.sv
`timescale 1ns/1ns
`default_nettype none

module vec_execute import vec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [CMD_W-1:0]  command,
    input  wire               bram_sel,
    input  wire               command_ready,
    input  wire  [DATA_W-1:0] data_a,
    input  wire  [DATA_W-1:0] data_b,
    input  wire               sender_busy,
    output logic [ADDR_W-1:0] rd_addr,
    output logic [ACC_W-1:0]  result,
    output logic              result_valid,
    output logic [DATA_W-1:0] elem,
    output logic              elem_valid,
    output logic              last
);

    logic                running;                       // sweep in progress
    logic                issue;                         // address taken this cycle
    logic                read_mode;
    logic                data_vld;                      // memory data belongs to the sweep
    logic                data_last;                     // it is element VEC_LEN-1
    logic [DATA_W-1:0]   sel_elem;
    logic [DATA_W-1:0]   abs_diff;
    logic [2*DATA_W-1:0] sq;
    logic [2*DATA_W-1:0] prod;
    logic [ACC_W-1:0]    term;
    logic [ACC_W-1:0]    acc;
    logic [ACC_W-1:0]    acc_next;

    assign read_mode = command[CMD_READ];
    // a read keeps one element in flight and waits on the sender
    assign issue = running & ~(read_mode & (sender_busy | data_vld));

    // per-element term
    always_comb begin
        sel_elem = bram_sel ? data_b : data_a;
        abs_diff = (data_a >= data_b) ? data_a - data_b : data_b - data_a;
        sq       = abs_diff * abs_diff;
        prod     = data_a * data_b;
        term     = '0;
        if (command[CMD_SUM] || command[CMD_AVG]) begin
            term = {{(ACC_W-DATA_W){1'b0}}, sel_elem};
        end else if (command[CMD_EUC_SQ]) begin
            term = {{(ACC_W-2*DATA_W){1'b0}}, sq};      // sum of squares, no root
        end else if (command[CMD_MAN]) begin
            term = {{(ACC_W-DATA_W){1'b0}}, abs_diff};
        end else if (command[CMD_DOT]) begin
            term = {{(ACC_W-2*DATA_W){1'b0}}, prod};
        end
    end

    assign acc_next = acc + term;

    // address sweep, data lags the address by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running      <= 1'b0;
            rd_addr      <= '0;
            data_vld     <= 1'b0;
            data_last    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            data_vld     <= issue;
            data_last    <= issue && (rd_addr == ADDR_W'(VEC_LEN - 1));
            result_valid <= data_vld && data_last && !read_mode; // one item per reduction
            if (command_ready && !command[CMD_WRITE]) begin
                running <= 1'b1;
                rd_addr <= '0;
            end else if (issue) begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == ADDR_W'(VEC_LEN - 1)) begin
                    running <= 1'b0;                    // last address issued
                end
            end
        end
    end

    // accumulator and final result
    always_ff @(posedge clk) begin
        if (command_ready) begin
            acc <= '0;
        end else if (data_vld) begin
            acc <= acc_next;
        end
        if (data_vld && data_last) begin
            result <= command[CMD_AVG] ? (acc_next >> AVG_SHIFT) : acc_next; // truncating average
        end
    end

    // element stream for read
    assign elem       = sel_elem;
    assign elem_valid = data_vld & read_mode;
    assign last       = data_last;

endmodule

`default_nettype wire

// File: source/result_tx.sv
`timescale 1ns/1ns
`default_nettype none

module result_tx import vec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [ACC_W-1:0]  result,
    input  wire               result_valid,
    input  wire  [DATA_W-1:0] elem,
    input  wire               elem_valid,
    input  wire               last,
    input  wire               tx_ready,
    output logic [7:0]        tx_data,
    output logic              tx_start,
    output logic              sender_busy,
    output logic              op_done
);

    logic [ACC_W-1:0] shreg;                            // outgoing bytes, msb byte first
    logic [2:0]       cnt;                              // bytes still pending
    logic             fin;                              // current item ends the operation

    assign tx_data     = shreg[ACC_W-1:ACC_W-8];        // held while tx_ready is low
    assign tx_start    = (cnt != 3'd0) & tx_ready;
    assign sender_busy = (cnt != 3'd0);

    // byte counter and completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= 3'd0;
            fin     <= 1'b0;
            op_done <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (result_valid) begin
                cnt <= 3'd4;                            // 32-bit result
                fin <= 1'b1;
            end else if (elem_valid) begin
                cnt <= 3'd2;                            // low byte, then padded high byte
                fin <= last;
            end else if (tx_start) begin
                cnt <= cnt - 1'b1;
                if (cnt == 3'd1 && fin) begin
                    op_done <= 1'b1;                    // cycle after the final tx_start
                end
            end
        end
    end

    // byte shift register
    always_ff @(posedge clk) begin
        if (result_valid) begin
            shreg <= result;
        end else if (elem_valid) begin
            shreg <= {elem[7:0], {(16-DATA_W){1'b0}}, elem[DATA_W-1:8], 16'h0000};
        end else if (tx_start) begin
            shreg <= shreg << 8;
        end
    end

endmodule

`default_nettype wire

// File: source/vec_coproc_top.sv
`timescale 1ns/1ns
`default_nettype none

module vec_coproc_top import vec_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        rx_ready,
    input  wire        rx_byte_t rx_data,
    input  wire        tx_ready,
    output logic [7:0] tx_data,
    output logic       tx_start,
    output logic       busy
);

    logic [CMD_W-1:0]  command;
    logic              bram_sel;
    logic              command_ready;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] data_a;
    logic [DATA_W-1:0] data_b;
    logic [ACC_W-1:0]  result;
    logic              result_valid;
    logic [DATA_W-1:0] elem;
    logic              elem_valid;
    logic              last;
    logic              sender_busy;
    logic              op_done;

    input_interface u_input_interface (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_ready      (rx_ready),
        .rx_data       (rx_data),
        .rd_addr       (rd_addr),
        .exec_done     (op_done),                       // sender marks the end of execution
        .command       (command),
        .bram_sel      (bram_sel),
        .command_ready (command_ready),
        .busy          (busy),
        .data_a        (data_a),
        .data_b        (data_b)
    );

    vec_execute u_vec_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .command       (command),
        .bram_sel      (bram_sel),
        .command_ready (command_ready),
        .data_a        (data_a),
        .data_b        (data_b),
        .sender_busy   (sender_busy),
        .rd_addr       (rd_addr),
        .result        (result),
        .result_valid  (result_valid),
        .elem          (elem),
        .elem_valid    (elem_valid),
        .last          (last)
    );

    result_tx u_result_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (result),
        .result_valid (result_valid),
        .elem         (elem),
        .elem_valid   (elem_valid),
        .last         (last),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .sender_busy  (sender_busy),
        .op_done      (op_done)
    );

endmodule

`default_nettype wire

// File: tb/tb_vec_coproc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_coproc import vec_pkg::*; ();

    logic              clk = 1'b0;
    logic              rst_n;
    logic              rx_ready;
    rx_byte_t          rx_data;
    logic              tx_ready;
    logic [7:0]        tx_data;
    logic              tx_start;
    logic              busy;

    logic [DATA_W-1:0] model_a [VEC_LEN];               // reference copy of vector A
    logic [DATA_W-1:0] model_b [VEC_LEN];               // reference copy of vector B
    logic [7:0]        tx_bytes [$];                    // every byte seen with tx_start
    logic [31:0]       stim_state;                      // lfsr for vectors and commands
    logic [31:0]       ready_state;                     // lfsr for the tx_ready pattern
    logic              stretch_mode;                    // long low stretches on tx_ready
    int                errors;
    int                bp_violations;

    always #50 clk = ~clk;                              // 100 ns period

    vec_coproc_top vec_coproc_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_ready (rx_ready),
        .rx_data  (rx_data),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .busy     (busy)
    );

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw(inout logic [31:0] state, input int nbits, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            value = {value[30:0], state[31]};
            state = lfsr_next(state);
        end
    endtask

    // reduction over the model vectors
    function automatic logic [31:0] expected_result(input logic [2:0] op, input logic sel);
        logic [31:0] acc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        int          i;
        acc = '0;
        for (i = 0; i < VEC_LEN; i++) begin
            a = 32'(model_a[i]);
            b = 32'(model_b[i]);
            d = (a > b) ? a - b : b - a;                // absolute difference
            case (op)
                OP_SUM, OP_AVG: acc = acc + (sel ? b : a);
                OP_EUC_SQ:      acc = acc + d * d;      // squared distance, no root
                OP_MAN:         acc = acc + d;
                default:        acc = acc + a * b;      // dot product
            endcase
        end
        return (op == OP_AVG) ? (acc >> AVG_SHIFT) : acc; // average truncates
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        #10;
        rx_ready    = 1'b1;                             // one-cycle strobe
        rx_data.raw = b;
        @(posedge clk);
        #10;
        rx_ready    = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy) @(negedge clk);                    // watchdog bounds this
    endtask

    task automatic check_idle(input string name);
        if (tx_start !== 1'b0 || busy !== 1'b0) begin
            errors++;
            $display("ERROR %s: expected tx_start=0 busy=0, actual tx_start=%b busy=%b",
                     name, tx_start, busy);
        end
    endtask

    // random command bytes, sent while the decoder is busy
    task automatic send_junk(input int n);
        logic [31:0] r;
        repeat (n) begin
            draw(stim_state, 4, r);
            send_byte({r[3], 4'b0000, r[2:0]});
        end
    endtask

    task automatic fill_random(input logic sel);
        logic [31:0] r;
        int          i;
        for (i = 0; i < VEC_LEN; i++) begin
            draw(stim_state, DATA_W, r);
            if (sel) model_b[i] = r[DATA_W-1:0];
            else     model_a[i] = r[DATA_W-1:0];
        end
    endtask

    task automatic write_vector(input logic sel);
        logic [DATA_W-1:0] v;
        int                i;
        send_byte({sel, 4'b0000, OP_WRITE});
        for (i = 0; i < VEC_LEN; i++) begin
            v = sel ? model_b[i] : model_a[i];
            send_byte(v[7:0]);                          // low byte first
            send_byte({{(16-DATA_W){1'b0}}, v[DATA_W-1:8]});
        end
        wait_idle();
    endtask

    task automatic read_back(input string name, input logic sel, input int junk);
        logic [15:0] expected;
        logic [15:0] actual;
        int          start;
        int          i;
        start = tx_bytes.size();
        send_byte({sel, 4'b0000, OP_READ});
        send_junk(junk);
        wait_idle();
        if (tx_bytes.size() - start != 2 * VEC_LEN) begin
            errors++;
            $display("ERROR %s byte count: expected %0d, actual %0d",
                     name, 2 * VEC_LEN, tx_bytes.size() - start);
        end else begin
            for (i = 0; i < VEC_LEN; i++) begin
                expected = 16'(sel ? model_b[i] : model_a[i]);
                actual   = {tx_bytes[start + 2 * i + 1], tx_bytes[start + 2 * i]};
                if (actual !== expected) begin
                    errors++;
                    $display("ERROR %s elem %0d: expected %0h, actual %0h",
                             name, i, expected, actual);
                end
            end
        end
    endtask

    task automatic run_reduction(input string name, input logic [2:0] op, input logic sel,
                                 input int junk);
        logic [31:0] expected;
        logic [31:0] actual;
        int          start;
        expected = expected_result(op, sel);
        start    = tx_bytes.size();
        send_byte({sel, 4'b0000, op});
        send_junk(junk);
        wait_idle();
        if (tx_bytes.size() - start != 4) begin
            errors++;
            $display("ERROR %s byte count: expected 4, actual %0d", name, tx_bytes.size() - start);
        end else begin
            actual = {tx_bytes[start], tx_bytes[start + 1], tx_bytes[start + 2],
                      tx_bytes[start + 3]};             // msb first
            if (actual !== expected) begin
                errors++;
                $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            end
        end
    endtask

    // all seven reductions in a randomly rotated order
    task automatic run_reductions(input string name);
        logic [31:0] r;
        logic [2:0]  op;
        logic        sel;
        int          i;
        int          k;
        draw(stim_state, 3, r);
        for (i = 0; i < 7; i++) begin
            k   = (i + int'(r)) % 7;                    // 0..3 sum/avg of A and B, 4..6 pairwise
            op  = (k < 4) ? ((k < 2) ? OP_SUM : OP_AVG) : 3'(k);
            sel = (k < 4) ? k[0] : 1'b0;
            run_reduction($sformatf("%s op%0d sel%0d", name, op, sel), op, sel, 0);
        end
    endtask

    // tx_ready pattern, high about three cycles in four
    initial begin
        logic [31:0] r;
        int          low_left;
        ready_state = 32'd99952;
        low_left    = 0;
        tx_ready    = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (low_left > 0) begin
                low_left--;
                tx_ready = 1'b0;                        // inside a low stretch
            end else begin
                draw(ready_state, 2, r);
                tx_ready = (r[1:0] != 2'b00);
                if (!tx_ready && stretch_mode) begin
                    draw(ready_state, 4, r);
                    low_left = int'(r[3:0]);            // up to 15 more low cycles
                end
            end
        end
    end

    // byte capture, sampled mid-cycle
    initial begin
        bp_violations = 0;
        forever begin
            @(negedge clk);
            if (tx_start) begin
                tx_bytes.push_back(tx_data);
                if (!tx_ready) begin
                    bp_violations++;
                    $display("tx_start was high while tx_ready was low at %0t", $time);
                end
            end
        end
    end

    // watchdog scaled by the bytes moved in all tests
    initial begin
        int total_bytes;
        total_bytes = 8 * (1 + 2 * VEC_LEN) + 16 * 5 + 16; // writes and reads, reductions, junk
        #(total_bytes * 40 * 100);                      // 40 cycles per byte at 100 ns
        $display("timeout: the run did not finish within %0d cycles", total_bytes * 40);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int start;
        stim_state   = 32'd99952;
        stretch_mode = 1'b0;
        errors       = 0;
        rst_n        = 1'b0;
        rx_ready     = 1'b0;
        rx_data      = '0;
        repeat (3) begin
            @(negedge clk);
            check_idle("reset_state in reset");
        end
        @(posedge clk);
        #10;
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("reset_state after reset");
        end

        fill_random(1'b0);
        fill_random(1'b1);
        write_vector(1'b0);
        write_vector(1'b1);
        read_back("write_read A", 1'b0, 0);
        read_back("write_read B", 1'b1, 0);

        run_reductions("reductions");
        stretch_mode = 1'b1;
        run_reductions("back_pressure");
        stretch_mode = 1'b0;

        read_back("busy_rules read A", 1'b0, 3);        // junk commands during the read
        run_reduction("busy_rules sum B", OP_SUM, 1'b1, 2);
        start = tx_bytes.size();
        send_byte({1'b0, 4'b0000, 3'd7});               // unused opcode while idle
        repeat (8) begin
            @(negedge clk);
            check_idle("busy_rules opcode 7");
        end
        if (tx_bytes.size() != start) begin
            errors++;
            $display("ERROR busy_rules opcode 7 bytes: expected 0, actual %0d",
                     tx_bytes.size() - start);
        end
        read_back("busy_rules A", 1'b0, 0);
        read_back("busy_rules B", 1'b1, 0);

        fill_random(1'b0);                              // new A, B stays
        write_vector(1'b0);
        run_reduction("rewrite dot", OP_DOT, 1'b0, 0);

        $display("errors: %0d wrong values, %0d tx_start without tx_ready",
                 errors, bp_violations);
        if (errors == 0 && bp_violations == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/vec_pkg.sv
source/vector_bram.sv
source/write_ctrl.sv
source/cmd_decoder.sv
source/input_interface.sv
source/vec_execute.sv
source/result_tx.sv
source/vec_coproc_top.sv
tb/tb_vec_coproc.sv

// File: Makefile
.PHONY: run clean

obj_dir/Vtb_vec_coproc: project.f $(wildcard source/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --timescale 1ns/1ns --top-module tb_vec_coproc -f project.f

run: obj_dir/Vtb_vec_coproc
	@out=$$(./obj_dir/Vtb_vec_coproc); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
